/* common/icu_pkg.sv */
/*
 widths and typedefs of the instruction control stage,
 decoded and issued instruction records, control and commit structs
*/
package icu_pkg;

    // up to 8 scoreboard slots
    parameter int COMMIT_ID_W = 3;
    parameter int DECINFO_W   = 16;

    typedef logic [31:0]            inst_addr_t;
    typedef logic [4:0]             reg_addr_t;
    typedef logic [11:0]            csr_addr_t;
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;
    typedef logic [DECINFO_W-1:0]   dec_info_t;

    // one instruction as delivered by the decoder
    typedef struct packed {
        inst_addr_t addr;
        logic       reg_we;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        logic       csr_we;
        csr_addr_t  csr_waddr;
        csr_addr_t  csr_raddr;
        logic [31:0] imm;
        dec_info_t  dec_info;
        logic       is_pred_branch;
    } dec_inst_t;

    // one lane towards execute
    typedef struct packed {
        logic       valid;
        commit_id_t commit_id;
        dec_inst_t  inst;
    } issued_inst_t;

    typedef struct packed {
        logic flush;
        logic stall_dispatch;
    } cu_ctrl_t;

    // retirement from writeback
    typedef struct packed {
        logic       valid;
        commit_id_t id;
    } commit_t;

    // per-lane strobes, bit 0 is lane 1
    typedef struct packed {
        logic [1:0] load;
        logic [1:0] clear;
        commit_id_t id1;
        commit_id_t id2;
    } issue_ctrl_t;

endpackage

/* icu/hdu.sv */
/*
 hazard detection unit: scoreboard of in-flight instructions,
 in-order dual issue check, commit id allocation, issue strobes
*/
`timescale 1ns/1ps

module hdu #(
    parameter int SB_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  reset_i,

    input  icu_pkg::dec_inst_t    inst1_i,
    input  icu_pkg::dec_inst_t    inst2_i,
    input  logic                  inst1_valid_i,
    input  logic                  inst2_valid_i,

    input  icu_pkg::commit_t      commit1_i,
    input  icu_pkg::commit_t      commit2_i,
    input  icu_pkg::cu_ctrl_t     ctrl_i,

    output icu_pkg::issue_ctrl_t  issue_ctrl_o,
    output logic [1:0]            issue_accept_o,
    output logic                  new_issue_stall_o
);

    // scoreboard state per slot
    logic [SB_DEPTH-1:0]   sb_busy_q;
    logic [SB_DEPTH-1:0]   sb_busy_d;
    logic [SB_DEPTH-1:0]   sb_we_q;
    icu_pkg::reg_addr_t    sb_rd_q [SB_DEPTH];

    logic [SB_DEPTH-1:0]   alloc1;
    logic [SB_DEPTH-1:0]   alloc2;
    logic [SB_DEPTH-1:0]   retire;

    logic                  free1_ok;
    logic                  free2_ok;
    icu_pkg::commit_id_t   free1_id;
    icu_pkg::commit_id_t   free2_id;

    logic                  haz1;
    logic                  haz2;
    logic                  pair_raw;
    logic                  pair_waw;
    logic                  acc1;
    logic                  acc2;

    // true when a busy writing slot overlaps the operands or rd of inst
    function automatic logic sb_hazard(input icu_pkg::dec_inst_t inst);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (sb_busy_q[i] && sb_we_q[i] && sb_rd_q[i] != '0) begin
                if (sb_rd_q[i] == inst.rs1 || sb_rd_q[i] == inst.rs2) begin
                    hit = 1'b1;
                end
                if (inst.reg_we && sb_rd_q[i] == inst.rd) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // two lowest free slots
    always_comb begin
        free1_ok = 1'b0;
        free2_ok = 1'b0;
        free1_id = '0;
        free2_id = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (!sb_busy_q[i]) begin
                if (!free1_ok) begin
                    free1_ok = 1'b1;
                    free1_id = icu_pkg::commit_id_t'(i);
                end else if (!free2_ok) begin
                    free2_ok = 1'b1;
                    free2_id = icu_pkg::commit_id_t'(i);
                end
            end
        end
    end

    // in-order issue decision
    always_comb begin
        haz1 = sb_hazard(inst1_i);
        haz2 = sb_hazard(inst2_i);
        // lane 2 depending on lane 1 in the same pair
        pair_raw = inst1_i.reg_we && inst1_i.rd != '0 &&
                   (inst1_i.rd == inst2_i.rs1 || inst1_i.rd == inst2_i.rs2);
        pair_waw = inst1_i.reg_we && inst2_i.reg_we && inst1_i.rd != '0 &&
                   inst1_i.rd == inst2_i.rd;
        acc1 = inst1_valid_i && !haz1 && free1_ok &&
               !ctrl_i.flush && !ctrl_i.stall_dispatch;
        acc2 = acc1 && inst2_valid_i && !haz2 && free2_ok && !pair_raw && !pair_waw;
    end

    // slot updates, commits are seen at the next edge only
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            alloc1[i] = acc1 && free1_id == icu_pkg::commit_id_t'(i);
            alloc2[i] = acc2 && free2_id == icu_pkg::commit_id_t'(i);
            retire[i] = (commit1_i.valid && commit1_i.id == icu_pkg::commit_id_t'(i)) ||
                        (commit2_i.valid && commit2_i.id == icu_pkg::commit_id_t'(i));
        end
        if (ctrl_i.flush) begin
            sb_busy_d = '0;
        end else begin
            sb_busy_d = (sb_busy_q & ~retire) | alloc1 | alloc2;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sb_busy_q <= '0;
        end else begin
            sb_busy_q <= sb_busy_d;
        end
    end

    // destination info of the newly allocated slots
    always_ff @(posedge clk) begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (alloc1[i]) begin
                sb_we_q[i] <= inst1_i.reg_we;
                sb_rd_q[i] <= inst1_i.rd;
            end else if (alloc2[i]) begin
                sb_we_q[i] <= inst2_i.reg_we;
                sb_rd_q[i] <= inst2_i.rd;
            end
        end
    end

    assign issue_accept_o    = {acc2, acc1};
    assign new_issue_stall_o = (inst1_valid_i && !acc1) || (inst2_valid_i && !acc2);

    // lanes hold under stall, flush always drops them
    assign issue_ctrl_o.load     = {acc2, acc1};
    assign issue_ctrl_o.clear[0] = ctrl_i.flush || (!acc1 && !ctrl_i.stall_dispatch);
    assign issue_ctrl_o.clear[1] = ctrl_i.flush || (!acc2 && !ctrl_i.stall_dispatch);
    assign issue_ctrl_o.id1      = free1_id;
    assign issue_ctrl_o.id2      = free2_id;

endmodule

/* icu/icu_issue.sv */
/*
 two-lane issue register towards execute,
 per-lane load, clear and hold
*/
`timescale 1ns/1ps

module icu_issue (
    input  logic                  clk,
    input  logic                  reset_i,

    input  icu_pkg::dec_inst_t    inst1_i,
    input  icu_pkg::dec_inst_t    inst2_i,
    input  icu_pkg::issue_ctrl_t  issue_ctrl_i,

    output icu_pkg::issued_inst_t issue1_o,
    output icu_pkg::issued_inst_t issue2_o
);

    // lane 0 is the older instruction
    icu_pkg::dec_inst_t     lane_inst [2];
    icu_pkg::commit_id_t    lane_id   [2];
    icu_pkg::issued_inst_t  lane_q    [2];

    assign lane_inst[0] = inst1_i;
    assign lane_inst[1] = inst2_i;
    assign lane_id[0]   = issue_ctrl_i.id1;
    assign lane_id[1]   = issue_ctrl_i.id2;

    // valid: load sets, clear drops, otherwise hold
    always_ff @(posedge clk) begin
        for (int n = 0; n < 2; n++) begin
            if (reset_i) begin
                lane_q[n].valid <= 1'b0;
            end else if (issue_ctrl_i.load[n]) begin
                lane_q[n].valid <= 1'b1;
            end else if (issue_ctrl_i.clear[n]) begin
                lane_q[n].valid <= 1'b0;
            end
        end
    end

    // payload only moves on load
    always_ff @(posedge clk) begin
        for (int n = 0; n < 2; n++) begin
            if (issue_ctrl_i.load[n]) begin
                lane_q[n].commit_id <= lane_id[n];
                lane_q[n].inst      <= lane_inst[n];
            end
        end
    end

    assign issue1_o = lane_q[0];
    assign issue2_o = lane_q[1];

endmodule

/* icu/icu.sv */
/*
 instruction control stage top level,
 hazard unit plus issue register
*/
`timescale 1ns/1ps

module icu #(
    parameter int SB_DEPTH = 8
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // from decoder, slot 1 is older
    input  icu_pkg::dec_inst_t    inst1_i,
    input  icu_pkg::dec_inst_t    inst2_i,
    input  logic                  inst1_valid_i,
    input  logic                  inst2_valid_i,

    // from writeback
    input  icu_pkg::commit_t      commit1_i,
    input  icu_pkg::commit_t      commit2_i,

    // from control unit
    input  icu_pkg::cu_ctrl_t     ctrl_i,

    // to execute
    output icu_pkg::issued_inst_t issue1_o,
    output icu_pkg::issued_inst_t issue2_o,

    // back to decoder
    output logic [1:0]            issue_accept_o,
    output logic                  new_issue_stall_o
);

    icu_pkg::issue_ctrl_t issue_ctrl;

    hdu #(
        .SB_DEPTH (SB_DEPTH)
    ) u_hdu (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst1_i           (inst1_i),
        .inst2_i           (inst2_i),
        .inst1_valid_i     (inst1_valid_i),
        .inst2_valid_i     (inst2_valid_i),
        .commit1_i         (commit1_i),
        .commit2_i         (commit2_i),
        .ctrl_i            (ctrl_i),
        .issue_ctrl_o      (issue_ctrl),
        .issue_accept_o    (issue_accept_o),
        .new_issue_stall_o (new_issue_stall_o)
    );

    icu_issue u_icu_issue (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst1_i      (inst1_i),
        .inst2_i      (inst2_i),
        .issue_ctrl_i (issue_ctrl),
        .issue1_o     (issue1_o),
        .issue2_o     (issue2_o)
    );

endmodule

/* sim/icu_checker.sv */
/*
 protocol assertions on the instruction control stage,
 bound into icu from the testbench
*/
`timescale 1ns/1ps

module icu_checker (
    input  logic                  clk,
    input  logic                  reset_i,
    input  icu_pkg::cu_ctrl_t     ctrl_i,
    input  logic [1:0]            issue_accept_o,
    input  icu_pkg::issued_inst_t issue1_o,
    input  icu_pkg::issued_inst_t issue2_o
);

    // failed assertions, read by the testbench
    int fail_count = 0;

    // in-order issue, lane 2 never alone
    accept_order: assert property (@(posedge clk) disable iff (reset_i)
        issue_accept_o[1] |-> issue_accept_o[0])
    else begin
        $error("lane 2 accepted without lane 1");
        fail_count++;
    end

    flush_clears: assert property (@(posedge clk) disable iff (reset_i)
        ctrl_i.flush |=> !issue1_o.valid && !issue2_o.valid)
    else begin
        $error("lane valid still set after flush");
        fail_count++;
    end

    // back-pressure keeps both lanes frozen
    stall_holds: assert property (@(posedge clk) disable iff (reset_i)
        ctrl_i.stall_dispatch && !ctrl_i.flush |=> $stable(issue1_o) && $stable(issue2_o))
    else begin
        $error("issue outputs changed during dispatch stall");
        fail_count++;
    end

    unique_ids: assert property (@(posedge clk) disable iff (reset_i)
        issue1_o.valid && issue2_o.valid |-> issue1_o.commit_id != issue2_o.commit_id)
    else begin
        $error("both lanes carry the same commit id");
        fail_count++;
    end

endmodule

/* sim/tb_icu.sv */
/*
 testbench for icu: clock, reset, directed and random stimulus,
 reference scoreboard model and value checks
*/
`timescale 1ns/1ps

module tb_icu;

    localparam int SB_DEPTH   = 4;
    localparam int CLK_PERIOD = 40;
    localparam int N_DIRECTED = 60;
    localparam int N_RANDOM   = 300;

    logic                  clk;
    logic                  reset_i;
    icu_pkg::dec_inst_t    inst1_i;
    icu_pkg::dec_inst_t    inst2_i;
    logic                  inst1_valid_i;
    logic                  inst2_valid_i;
    icu_pkg::commit_t      commit1_i;
    icu_pkg::commit_t      commit2_i;
    icu_pkg::cu_ctrl_t     ctrl_i;
    icu_pkg::issued_inst_t issue1_o;
    icu_pkg::issued_inst_t issue2_o;
    logic [1:0]            issue_accept_o;
    logic                  new_issue_stall_o;

    int errors;
    int seed;

    // reference scoreboard and predicted lanes
    logic [SB_DEPTH-1:0]   m_busy;
    logic [SB_DEPTH-1:0]   m_we;
    icu_pkg::reg_addr_t    m_rd [SB_DEPTH];
    icu_pkg::issued_inst_t exp1;
    icu_pkg::issued_inst_t exp2;

    icu #(
        .SB_DEPTH (SB_DEPTH)
    ) DUT (
        .clk               (clk),
        .reset_i           (reset_i),
        .inst1_i           (inst1_i),
        .inst2_i           (inst2_i),
        .inst1_valid_i     (inst1_valid_i),
        .inst2_valid_i     (inst2_valid_i),
        .commit1_i         (commit1_i),
        .commit2_i         (commit2_i),
        .ctrl_i            (ctrl_i),
        .issue1_o          (issue1_o),
        .issue2_o          (issue2_o),
        .issue_accept_o    (issue_accept_o),
        .new_issue_stall_o (new_issue_stall_o)
    );

    bind icu icu_checker u_checker (
        .clk            (clk),
        .reset_i        (reset_i),
        .ctrl_i         (ctrl_i),
        .issue_accept_o (issue_accept_o),
        .issue1_o       (issue1_o),
        .issue2_o       (issue2_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((N_DIRECTED + N_RANDOM) * CLK_PERIOD + 20 * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic mismatch(input string name, input logic [127:0] exp_v,
                            input logic [127:0] got_v);
        $display("Mismatch %s: expected %h, got %h", name, exp_v, got_v);
        errors++;
    endtask

    // decoded instruction with random payload
    function automatic icu_pkg::dec_inst_t make_inst(input int rd, input int rs1,
                                                     input int rs2, input logic we);
        icu_pkg::dec_inst_t d;
        d.addr           = $random(seed);
        d.reg_we         = we;
        d.rd             = icu_pkg::reg_addr_t'(rd);
        d.rs1            = icu_pkg::reg_addr_t'(rs1);
        d.rs2            = icu_pkg::reg_addr_t'(rs2);
        d.csr_we         = 1'($random(seed));
        d.csr_waddr      = icu_pkg::csr_addr_t'($random(seed));
        d.csr_raddr      = icu_pkg::csr_addr_t'($random(seed));
        d.imm            = $random(seed);
        d.dec_info       = icu_pkg::dec_info_t'($random(seed));
        d.is_pred_branch = 1'($random(seed));
        return d;
    endfunction

    function automatic logic model_hazard(input icu_pkg::dec_inst_t d);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (m_busy[i] && m_we[i] && m_rd[i] != 5'd0) begin
                if (m_rd[i] == d.rs1 || m_rd[i] == d.rs2 || (d.reg_we && m_rd[i] == d.rd)) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    // one clock with inputs already driven after the falling edge
    task automatic run_cycle();
        logic [1:0]          acc;
        logic                stall;
        logic                raw;
        logic                waw;
        int                  f1;
        int                  f2;
        logic [SB_DEPTH-1:0] nb;
        #2;
        f1 = -1;
        f2 = -1;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (!m_busy[i] && f1 < 0) begin
                f1 = i;
            end else if (!m_busy[i] && f2 < 0) begin
                f2 = i;
            end
        end
        raw = inst1_i.reg_we && inst1_i.rd != 5'd0 &&
              (inst1_i.rd == inst2_i.rs1 || inst1_i.rd == inst2_i.rs2);
        waw = inst1_i.reg_we && inst2_i.reg_we && inst1_i.rd != 5'd0 &&
              inst1_i.rd == inst2_i.rd;
        acc[0] = inst1_valid_i && !model_hazard(inst1_i) && f1 >= 0 &&
                 !ctrl_i.flush && !ctrl_i.stall_dispatch;
        acc[1] = acc[0] && inst2_valid_i && !model_hazard(inst2_i) && f2 >= 0 && !raw && !waw;
        stall  = (inst1_valid_i && !acc[0]) || (inst2_valid_i && !acc[1]);
        assert (issue_accept_o === acc)
        else mismatch("issue_accept_o", 128'(acc), 128'(issue_accept_o));
        assert (new_issue_stall_o === stall)
        else mismatch("new_issue_stall_o", 128'(stall), 128'(new_issue_stall_o));

        // scoreboard next state, commits ignored under flush
        nb = m_busy;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if ((commit1_i.valid && commit1_i.id == icu_pkg::commit_id_t'(i)) ||
                (commit2_i.valid && commit2_i.id == icu_pkg::commit_id_t'(i))) begin
                nb[i] = 1'b0;
            end
            if (acc[0] && i == f1) begin
                nb[i]   = 1'b1;
                m_we[i] = inst1_i.reg_we;
                m_rd[i] = inst1_i.rd;
            end
            if (acc[1] && i == f2) begin
                nb[i]   = 1'b1;
                m_we[i] = inst2_i.reg_we;
                m_rd[i] = inst2_i.rd;
            end
        end
        m_busy = ctrl_i.flush ? '0 : nb;

        if (acc[0]) begin
            exp1 = {1'b1, icu_pkg::commit_id_t'(f1), inst1_i};
        end else if (ctrl_i.flush || !ctrl_i.stall_dispatch) begin
            exp1.valid = 1'b0;
        end
        if (acc[1]) begin
            exp2 = {1'b1, icu_pkg::commit_id_t'(f2), inst2_i};
        end else if (ctrl_i.flush || !ctrl_i.stall_dispatch) begin
            exp2.valid = 1'b0;
        end

        @(posedge clk);
        #2;
        assert (issue1_o.valid === exp1.valid && (!exp1.valid || issue1_o === exp1))
        else mismatch("issue1_o", 128'(exp1), 128'(issue1_o));
        assert (issue2_o.valid === exp2.valid && (!exp2.valid || issue2_o === exp2))
        else mismatch("issue2_o", 128'(exp2), 128'(issue2_o));
        @(negedge clk);
    endtask

    task automatic drive_pair(input icu_pkg::dec_inst_t a, input logic va,
                              input icu_pkg::dec_inst_t b, input logic vb);
        inst1_i       = a;
        inst2_i       = b;
        inst1_valid_i = va;
        inst2_valid_i = vb;
    endtask

    task automatic drive_commits(input int a, input logic va, input int b, input logic vb);
        commit1_i = {va, icu_pkg::commit_id_t'(a)};
        commit2_i = {vb, icu_pkg::commit_id_t'(b)};
    endtask

    task automatic drain();
        drive_pair(inst1_i, 1'b0, inst2_i, 1'b0);
        ctrl_i = '0;
        ctrl_i.flush = 1'b1;
        run_cycle();
        ctrl_i = '0;
    endtask

    initial begin
        icu_pkg::dec_inst_t held;
        int                 idx;
        errors        = 0;
        seed          = 32'h71bf1e86;
        reset_i       = 1'b1;
        inst1_i       = '0;
        inst2_i       = '0;
        inst1_valid_i = 1'b0;
        inst2_valid_i = 1'b0;
        commit1_i     = '0;
        commit2_i     = '0;
        ctrl_i        = '0;
        m_busy        = '0;
        m_we          = '0;
        exp1          = '0;
        exp2          = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // independent pair from empty scoreboard
        drive_pair(make_inst(1, 2, 3, 1'b1), 1'b1, make_inst(4, 5, 6, 1'b1), 1'b1);
        run_cycle();
        assert (issue1_o.commit_id == 3'd0 && issue2_o.commit_id == 3'd1)
        else mismatch("issue ids", 128'(6'o01),
                      128'({issue1_o.commit_id, issue2_o.commit_id}));
        drive_pair(inst1_i, 1'b0, inst2_i, 1'b0);
        drive_commits(0, 1'b1, 1, 1'b1);
        run_cycle();
        drive_commits(0, 1'b0, 0, 1'b0);

        // read after write inside the pair, then re-presented slot 2
        held = make_inst(8, 7, 9, 1'b1);
        drive_pair(make_inst(7, 1, 2, 1'b1), 1'b1, held, 1'b1);
        run_cycle();
        drive_pair(held, 1'b1, inst2_i, 1'b0);
        run_cycle();
        drive_commits(0, 1'b1, 0, 1'b0);
        run_cycle();
        drive_commits(0, 1'b0, 0, 1'b0);
        run_cycle();
        // write after write in the pair, register zero never blocks
        drive_pair(make_inst(10, 1, 2, 1'b1), 1'b1, make_inst(10, 3, 4, 1'b1), 1'b1);
        run_cycle();
        drive_pair(make_inst(0, 5, 6, 1'b1), 1'b1, make_inst(0, 0, 0, 1'b1), 1'b1);
        run_cycle();
        drain();

        // four in flight fill the scoreboard
        drive_pair(make_inst(1, 0, 0, 1'b1), 1'b1, make_inst(2, 0, 0, 1'b1), 1'b1);
        run_cycle();
        drive_pair(make_inst(3, 0, 0, 1'b1), 1'b1, make_inst(4, 0, 0, 1'b0), 1'b1);
        run_cycle();
        drive_pair(make_inst(5, 0, 0, 1'b1), 1'b1, make_inst(6, 0, 0, 1'b1), 1'b1);
        run_cycle();
        drive_commits(1, 1'b1, 2, 1'b1);
        run_cycle();
        drive_commits(0, 1'b0, 0, 1'b0);
        run_cycle();

        // dispatch stall with a commit underneath
        ctrl_i.stall_dispatch = 1'b1;
        drive_pair(make_inst(9, 0, 0, 1'b1), 1'b1, make_inst(11, 0, 0, 1'b1), 1'b1);
        drive_commits(0, 1'b1, 3, 1'b1);
        run_cycle();
        drive_commits(0, 1'b0, 0, 1'b0);
        repeat (2) run_cycle();
        ctrl_i.stall_dispatch = 1'b0;
        run_cycle();

        // flush then fresh ids
        drain();
        drive_pair(make_inst(12, 0, 0, 1'b1), 1'b1, make_inst(13, 0, 0, 1'b1), 1'b1);
        run_cycle();
        drain();

        // random phase against the model
        for (int c = 0; c < N_RANDOM; c++) begin
            drive_pair(make_inst(int'($unsigned($random(seed)) % 6),
                                 int'($unsigned($random(seed)) % 6),
                                 int'($unsigned($random(seed)) % 6), 1'($random(seed))),
                       1'($random(seed)),
                       make_inst(int'($unsigned($random(seed)) % 6),
                                 int'($unsigned($random(seed)) % 6),
                                 int'($unsigned($random(seed)) % 6), 1'($random(seed))),
                       1'($random(seed)));
            idx = int'($unsigned($random(seed)) % SB_DEPTH);
            drive_commits(idx, m_busy[idx] && 1'($random(seed)), 0, 1'b0);
            ctrl_i.flush          = ($unsigned($random(seed)) % 32) == 0;
            ctrl_i.stall_dispatch = ($unsigned($random(seed)) % 8) == 0;
            run_cycle();
        end

        $display("checks done: %0d value errors, %0d assertion failures",
                 errors, DUT.u_checker.fail_count);
        if (errors == 0 && DUT.u_checker.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* flist.f */
common/icu_pkg.sv
icu/hdu.sv
icu/icu_issue.sv
icu/icu.sv
sim/icu_checker.sv
sim/tb_icu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the icu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module tb_icu -f flist.f -o sim_icu

output=$(./obj_dir/sim_icu)
echo "$output"

if echo "$output" | grep -q '\*\*\* TEST PASSED \*\*\*'; then
    exit 0
else
    exit 1
fi
